/* hdl/windowfile_pkg.sv */
// Windowed register file definitions: sizes, group codes and the register number view
`default_nettype none

package windowfile_pkg;

	// Width of one architectural register
	localparam int DATA_W = 32;

	// Globals r0 to r7, with r0 hardwired to zero
	localparam int NUM_GLOBALS = 8;

	localparam int NUM_WINDOWS = 4; // Overlapping windows in the ring
	localparam int WIN_W = $clog2(NUM_WINDOWS); // Window number width

	// Each visible group (outs, locals, ins) has eight registers
	localparam int REGS_PER_GROUP = 8;
	localparam int OFFSET_W = $clog2(REGS_PER_GROUP);
	localparam int GROUP_W = 2; // Upper bits of a register number pick the group
	localparam int REG_NUM_W = GROUP_W + OFFSET_W; // 32 visible register numbers

	// Physical registers owned by each window: its outs plus its locals
	localparam int WINDOW_STRIDE = 16;
	localparam int NUM_WINDOWED = NUM_WINDOWS * WINDOW_STRIDE;
	localparam int PHYS_W = $clog2(NUM_WINDOWED); // Physical windowed index width

	// Group codes as found in the top two bits of the register number
	localparam logic [GROUP_W-1:0] GRP_GLOBAL = 2'd0;
	localparam logic [GROUP_W-1:0] GRP_OUT = 2'd1; // r8 to r15
	localparam logic [GROUP_W-1:0] GRP_LOCAL = 2'd2; // r16 to r23
	localparam logic [GROUP_W-1:0] GRP_IN = 2'd3; // r24 to r31

	// Register number seen either as a flat index or as group plus offset
	typedef union packed {
		logic [REG_NUM_W-1:0] flat; // r0 to r31
		struct packed {
			logic [GROUP_W-1:0] group; // Global, out, local or in
			logic [OFFSET_W-1:0] offset; // Position inside the group
		} parts;
	} reg_addr_u;

endpackage

`default_nettype wire

/* hdl/global_bank.sv */
// Global register bank holding r1 to r7, with r0 always reading as zero
`timescale 1ns/1ps
`default_nettype none

module global_bank import windowfile_pkg::*; (
	input  logic                clk,
	input  logic                reset, // Synchronous, clears every global
	input  logic                global_we, // Write strobe from the steering block
	input  logic [OFFSET_W-1:0] offset, // Global index, 0 is r0
	input  logic [DATA_W-1:0]   data_in,
	output logic [DATA_W-1:0]   global_rdata
);

	// Only r1 to r7 have flops, r0 is a constant
	logic [DATA_W-1:0] regs [1:NUM_GLOBALS-1];

	logic is_r0; // High when the offset points at the hardwired zero

	assign is_r0 = (offset == '0);

	// Write port, a write aimed at r0 is simply dropped
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < NUM_GLOBALS; i++) begin
				regs[i] <= '0; // Every global back to zero
			end
		end else if (global_we && !is_r0) begin
			regs[offset] <= data_in;
		end
	end

	// Eight-way read selection, r0 returns zero
	always_comb begin
		global_rdata = '0;
		if (!is_r0) begin
			global_rdata = regs[offset]; // Combinational read in the same cycle
		end
	end

endmodule

`default_nettype wire

/* hdl/window_bank.sv */
// Windowed register bank with 64 physical registers shared by four overlapping windows
`timescale 1ns/1ps
`default_nettype none

module window_bank import windowfile_pkg::*; (
	input  logic                clk,
	input  logic                reset, // Synchronous, clears all 64 registers
	input  logic                window_we, // Trusted as is, already qualified by group
	input  logic [WIN_W-1:0]    window, // Current window from the top level
	input  logic [GROUP_W-1:0]  group, // Out, local or in
	input  logic [OFFSET_W-1:0] offset, // Register inside the group
	input  logic [DATA_W-1:0]   data_in,
	output logic [DATA_W-1:0]   window_rdata
);

	// Physical storage for all windows together
	logic [DATA_W-1:0] regs [NUM_WINDOWED];

	logic [PHYS_W-1:0] window_base; // First physical register owned by this window
	logic [PHYS_W-1:0] group_base; // Distance of the group from the window base
	logic [PHYS_W-1:0] phys_idx; // Final index, shared by the write and read paths

	// Each window owns sixteen registers, the product wraps at 64 by width alone
	assign window_base = PHYS_W'(window) * PHYS_W'(WINDOW_STRIDE);

	// Outs sit at the base, locals right above them, ins in the next window's outs
	always_comb begin
		case (group)
			GRP_OUT:   group_base = '0;
			GRP_LOCAL: group_base = PHYS_W'(REGS_PER_GROUP);
			GRP_IN:    group_base = PHYS_W'(WINDOW_STRIDE); // Overlaps window w+1
			default:   group_base = '0; // Global code, the read result is not used
		endcase
	end

	// Modulo-64 sum, so window 3's ins land on window 0's outs
	assign phys_idx = window_base + group_base + PHYS_W'(offset);

	// One write per edge at the mapped index
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_WINDOWED; i++) begin
				regs[i] <= '0;
			end
		end else if (window_we) begin
			regs[phys_idx] <= data_in; // Visible to reads from the next cycle on
		end
	end

	// Read uses the very same index as the write
	assign window_rdata = regs[phys_idx];

endmodule

`default_nettype wire

/* hdl/access_steer.sv */
// Access decoder that steers writes to one bank and picks the read data for the port
`timescale 1ns/1ps
`default_nettype none

module access_steer import windowfile_pkg::*; (
	input  logic                enable, // Marks an access in this cycle
	input  logic                rw, // Low reads, high writes
	input  reg_addr_u           r_num, // Visible register number
	input  logic [DATA_W-1:0]   global_rdata,
	input  logic [DATA_W-1:0]   window_rdata,
	output logic                global_we,
	output logic                window_we,
	output logic [GROUP_W-1:0]  group, // Group field for the window mapping
	output logic [OFFSET_W-1:0] offset, // Shared by both banks
	output logic [DATA_W-1:0]   data_out
);

	logic is_global; // Register number falls in r0 to r7
	logic wr_cycle; // Qualified write
	logic rd_cycle; // Qualified read

	// Split the register number once, everything below works on the parts view
	assign group = r_num.parts.group;
	assign offset = r_num.parts.offset;

	assign is_global = (group == GRP_GLOBAL);
	assign wr_cycle = enable && rw;
	assign rd_cycle = enable && !rw;

	// Exactly one bank sees a write, the other strobe stays low
	assign global_we = wr_cycle && is_global;
	assign window_we = wr_cycle && !is_global;

	// The port is zero unless a read is in progress, there is no tristate bus here
	always_comb begin
		data_out = '0;
		if (rd_cycle) begin
			if (is_global) begin
				data_out = global_rdata; // Includes r0, which the bank returns as zero
			end else begin
				data_out = window_rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/reg_window_file.sv */
// Windowed integer register file top, one access port over global and windowed banks
`timescale 1ns/1ps
`default_nettype none

module reg_window_file import windowfile_pkg::*; (
	input  logic              clk,
	input  logic              reset, // Synchronous, active high
	input  logic              enable, // Access strobe
	input  logic              rw, // 0 read, 1 write
	input  logic [WIN_W-1:0]  window, // Current window, set from outside
	input  reg_addr_u         r_num, // Visible register r0 to r31
	input  logic [DATA_W-1:0] data_in, // Write word
	output logic [DATA_W-1:0] data_out // Combinational read word
);

	logic                global_we; // Write strobe for r1 to r7
	logic                window_we; // Write strobe for the windowed bank
	logic [GROUP_W-1:0]  group;
	logic [OFFSET_W-1:0] offset;
	logic [DATA_W-1:0]   global_rdata;
	logic [DATA_W-1:0]   window_rdata;

	// Decodes the access and merges the two read paths
	access_steer u_access_steer (
		.enable       (enable),
		.rw           (rw),
		.r_num        (r_num),
		.global_rdata (global_rdata),
		.window_rdata (window_rdata),
		.global_we    (global_we),
		.window_we    (window_we),
		.group        (group),
		.offset       (offset),
		.data_out     (data_out)
	);

	// Both banks decode the same offset in parallel
	global_bank u_global_bank (
		.clk          (clk),
		.reset        (reset),
		.global_we    (global_we),
		.offset       (offset),
		.data_in      (data_in),
		.global_rdata (global_rdata)
	);

	window_bank u_window_bank (
		.clk          (clk),
		.reset        (reset),
		.window_we    (window_we),
		.window       (window), // Straight from the port, not through the decoder
		.group        (group),
		.offset       (offset),
		.data_in      (data_in),
		.window_rdata (window_rdata)
	);

endmodule

`default_nettype wire

/* sim/reg_window_file_assert.sv */
// Port-level assertions for the windowed register file, attached to the top level
`timescale 1ns/1ps
`default_nettype none

module reg_window_file_assert import windowfile_pkg::*; (
	input logic              clk,
	input logic              reset,
	input logic              enable,
	input logic              rw,
	input logic [WIN_W-1:0]  window,
	input reg_addr_u         r_num,
	input logic [DATA_W-1:0] data_in,
	input logic [DATA_W-1:0] data_out
);

	logic rd_cycle;
	logic wr_cycle;

	assign rd_cycle = enable && !rw;
	assign wr_cycle = enable && rw;

	// r0 is hardwired to zero in every window
	a_r0_zero: assert property (@(posedge clk) (rd_cycle && r_num.flat == '0) |-> data_out == '0)
		else $error("Read of r0 returned a nonzero word");

	a_idle_zero: assert property (@(posedge clk) !rd_cycle |-> data_out == '0)
		else $error("data_out is not zero outside a read");

	// Write then read back of the same register in the same window
	a_write_read: assert property (@(posedge clk) disable iff (reset)
		(wr_cycle && r_num.flat != '0) ##1
		(rd_cycle && r_num.flat == $past(r_num.flat) && window == $past(window))
		|-> data_out == $past(data_in))
		else $error("Read after write did not return the written word");

endmodule

bind reg_window_file reg_window_file_assert u_reg_window_file_assert (
	.clk      (clk),
	.reset    (reset),
	.enable   (enable),
	.rw       (rw),
	.window   (window),
	.r_num    (r_num),
	.data_in  (data_in),
	.data_out (data_out)
);

`default_nettype wire

/* sim/reg_window_file_tb.sv */
// Self-checking testbench for the windowed register file with reference model and LFSR stimulus
`timescale 1ns/1ps
`default_nettype none

module reg_window_file_tb import windowfile_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1; // Inputs change this long after the rising edge
	localparam int SAMPLE_DELAY = CLK_PERIOD - 1; // data_out is sampled just before the next edge
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 1500;
	// Reset, the directed tests and the random mix come to about 2000 cycles
	localparam int EXPECTED_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = EXPECTED_CYCLES * 3 / 2;
	localparam logic [15:0] LFSR_SEED = 16'd68;

	logic              clk;
	logic              reset;
	logic              enable;
	logic              rw;
	logic [WIN_W-1:0]  window;
	reg_addr_u         r_num;
	logic [DATA_W-1:0] data_in;
	logic [DATA_W-1:0] data_out;

	// Globals sit at 0 to 7 and physical windowed registers at 8 to 71
	logic [DATA_W-1:0] model [NUM_GLOBALS + NUM_WINDOWED];

	logic [15:0] lfsr_state;
	string       test_name;
	int          error_count;
	int          cycle_count;

	reg_window_file u_reg_window_file (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.rw       (rw),
		.window   (window),
		.r_num    (r_num),
		.data_in  (data_in),
		.data_out (data_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Model slot of a visible register where windowed groups follow the modulo-64 ring
	function automatic int model_index(input logic [WIN_W-1:0] win, input reg_addr_u rn);
		int grp_off;
		if (rn.parts.group == GRP_GLOBAL) begin
			return int'(rn.parts.offset);
		end
		case (rn.parts.group)
			GRP_OUT:   grp_off = 0;
			GRP_LOCAL: grp_off = 8;
			default:   grp_off = 16; // Ins are the outs of the next window
		endcase
		return NUM_GLOBALS + ((int'(win) * WINDOW_STRIDE + grp_off + int'(rn.parts.offset))
			% NUM_WINDOWED);
	endfunction

	// Expected port word for the inputs of the current cycle
	function automatic logic [DATA_W-1:0] expected_read(input logic en, input logic wr,
			input logic [WIN_W-1:0] win, input reg_addr_u rn);
		if (!(en && !wr)) begin
			return '0; // The port is idle outside a read
		end
		if (rn.flat == '0) begin
			return '0;
		end
		return model[model_index(win, rn)];
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400; // Taps 16, 14, 13, 11
		end
		return n;
	endfunction

	// Collects n random bits with one LFSR step per bit
	task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[DATA_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "Mismatch on data_out");
		end
	endtask

	task automatic drive(input logic en, input logic wr, input int win, input int rn,
			input logic [DATA_W-1:0] d);
		@(posedge clk);
		#DRIVE_DELAY;
		enable = en;
		rw = wr;
		window = WIN_W'(win);
		r_num.flat = REG_NUM_W'(rn);
		data_in = d;
	endtask

	// One idle cycle that also switches the name used by the compare process
	task automatic start_test(input string name);
		@(posedge clk);
		#DRIVE_DELAY;
		test_name = name;
		enable = 1'b0;
		rw = 1'b0;
	endtask

	task automatic read_all();
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int r = 0; r < 32; r++) begin
				drive(1'b1, 1'b0, w, r, '0);
			end
		end
	endtask

	task automatic random_mix(input int cycles);
		logic [DATA_W-1:0] b_en;
		logic [DATA_W-1:0] b_rw;
		logic [DATA_W-1:0] b_win;
		logic [DATA_W-1:0] b_rn;
		logic [DATA_W-1:0] b_data;
		for (int i = 0; i < cycles; i++) begin
			take_bits(2, b_en); // Enable high three cycles in four
			take_bits(1, b_rw);
			take_bits(WIN_W, b_win);
			take_bits(REG_NUM_W, b_rn);
			take_bits(DATA_W, b_data);
			drive(|b_en[1:0], b_rw[0], int'(b_win), int'(b_rn), b_data);
		end
	endtask

	// Reset held mid-run while idle and write strobes keep coming
	task automatic hold_reset(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			reset = 1'b1;
			enable = i[0];
			rw = 1'b1;
			r_num.flat = REG_NUM_W'(i + 9);
			data_in = 32'hDEAD_0000 | i;
		end
		@(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		enable = 1'b0;
	endtask

	// Model follows the DUT at each edge and reset wins over any write
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_GLOBALS + NUM_WINDOWED; i++) begin
				model[i] = '0;
			end
		end else if (enable && rw && r_num.flat != '0) begin
			model[model_index(window, r_num)] = data_in;
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			#SAMPLE_DELAY;
			check_word(test_name, expected_read(enable, rw, window, r_num), data_out);
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$fatal(1, "Timeout");
	end

	initial begin
		reset = 1'b1;
		enable = 1'b0;
		rw = 1'b0;
		window = '0;
		r_num = '0;
		data_in = '0;
		lfsr_state = LFSR_SEED;
		error_count = 0;
		test_name = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		start_test("reset_zero");
		read_all();

		start_test("globals");
		for (int g = 0; g < NUM_GLOBALS; g++) begin
			drive(1'b1, 1'b1, g % NUM_WINDOWS, g, 32'h6100_0000 | (g * 32'h0101));
		end
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int g = 0; g < NUM_GLOBALS; g++) begin
				drive(1'b1, 1'b0, w, g, '0); // Same globals in every window
			end
		end

		start_test("overlap");
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				drive(1'b1, 1'b1, w, 8 + k, 32'h0C00_0000 | (w << 8) | k);
			end
		end
		// The ins of window w-1 are the outs of window w and window 3 wraps onto 0
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				drive(1'b1, 1'b0, (w + NUM_WINDOWS - 1) % NUM_WINDOWS, 24 + k, '0);
			end
		end

		start_test("locals");
		for (int w = 0; w < NUM_WINDOWS; w++) begin
			for (int k = 0; k < 8; k++) begin
				drive(1'b1, 1'b1, w, 16 + k, 32'h1A00_0000 | (w << 12) | (k << 4));
				drive(1'b1, 1'b0, w, 16 + k, '0); // Read back right after the write
			end
		end
		read_all(); // Every other group must be untouched

		start_test("random_mix");
		random_mix(RANDOM_CYCLES);

		start_test("idle_write");
		for (int i = 0; i < 8; i++) begin
			drive(1'b0, i[0], i % NUM_WINDOWS, i * 4, 32'hFFFF_0000 | i);
			drive(1'b1, 1'b1, i % NUM_WINDOWS, i * 4 + 1, 32'h5500_0000 | i);
		end
		hold_reset(4);
		read_all();

		start_test("done");
		@(posedge clk);
		if (error_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "Checks failed");
		end
	end

endmodule

`default_nettype wire

/* reg_window_file.f */
hdl/windowfile_pkg.sv
hdl/global_bank.sv
hdl/window_bank.sv
hdl/access_steer.sv
hdl/reg_window_file.sv
sim/reg_window_file_assert.sv
sim/reg_window_file_tb.sv

/* Bender.yml */
package:
  name: reg_window_file

sources:
  - files:
      - hdl/windowfile_pkg.sv
      - hdl/global_bank.sv
      - hdl/window_bank.sv
      - hdl/access_steer.sv
      - hdl/reg_window_file.sv
  - target: simulation
    files:
      - sim/reg_window_file_assert.sv
      - sim/reg_window_file_tb.sv
